// ==== hw/smi_defs.svh ====
// build-time constants for the SMI controller; the divider must be 2 or more
// register offsets are 4-bit byte addresses on the AXI4-Lite port
`ifndef SMI_DEFS_SVH
`define SMI_DEFS_SVH

// ----------------------------------------
// MDC pacing

// clk cycles per MDC half-period, so MDC = clk / (2 * divide)
`define SMI_CLOCK_DIVIDE 4

// clause 22 preamble, all ones
`define SMI_PREAMBLE_BITS 32

// ----------------------------------------
// register map (byte offsets)

`define SMI_REG_TX     4'h0
`define SMI_REG_RX     4'h4
`define SMI_REG_STATUS 4'h8

`endif

// ==== hw/smiPkg.sv ====
// shared types for the SMI controller; clause 22 frames only
// AXI4-Lite channels carry a 4-bit address, single beats only
package smiPkg;

`include "smi_defs.svh"

    // clause 22 opcodes
    typedef enum logic [1:0] {
        opWrite = 2'b01,
        opRead  = 2'b10
    } smiOp;

    // ----------------------------------------
    // frame word, MSB goes out first on MDIO

    typedef struct packed {
        logic [1:0]  startCode;   // 01 for clause 22
        smiOp        opCode;
        logic [4:0]  phyAddr;
        logic [4:0]  regAddr;
        logic [1:0]  turnaround;  // 10 on writes, released on reads
        logic [15:0] data;
    } smiFrameFields;

    // serializer shifts raw and decodes field
    typedef union packed {
        smiFrameFields field;
        logic [31:0]   raw;
    } smiFrame;

    // read view of the RX register
    typedef struct packed {
        logic [14:0] reserved;
        logic        valid;      // cleared by reading RX
        logic [15:0] data;
    } smiRxWord;

    // visible registers
    typedef enum logic [3:0] {
        regTx     = `SMI_REG_TX,
        regRx     = `SMI_REG_RX,
        regStatus = `SMI_REG_STATUS
    } smiReg;

    // AXI response codes in use
    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respSlvErr = 2'b10
    } smiResp;

    // ----------------------------------------
    // AXI4-Lite channels

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;    // whole word is always written
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axiReq;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiRsp;

endpackage

// ==== hw/ethernetSmiClockUnit.sv ====
// free-running MDC phase tick; needs SMI_CLOCK_DIVIDE >= 2
`timescale 1ns/1ns
`include "smi_defs.svh"

module ethernetSmiClockUnit (
    input  logic clk,
    input  logic reset,
    output logic finalCycle    // one clk wide, once per MDC half-period
);

    localparam int countWidth = $clog2(`SMI_CLOCK_DIVIDE);

    logic [countWidth-1:0] count;

    // count down and wrap, never stops so every frame starts on a tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= countWidth'(`SMI_CLOCK_DIVIDE - 1);
        end else if (count == '0) begin
            count <= countWidth'(`SMI_CLOCK_DIVIDE - 1);  // reload
        end else begin
            count <= count - 1'b1;
        end
    end

    assign finalCycle = (count == '0);

    // ticks are spaced by the divider, so two in a row means a broken counter
    tickSpacing: assert property (@(posedge clk) disable iff (reset)
        finalCycle |=> !finalCycle);

endmodule

// ==== hw/ethernetSmiUnit.sv ====
// clause 22 serializer, one bit per MDC period; MDC idles low between frames
// read data is captured on the ticks that raise MDC
`timescale 1ns/1ns
`include "smi_defs.svh"

module ethernetSmiUnit (
    input  logic           clk,
    input  logic           reset,
    input  smiPkg::smiFrame transmitData,
    output logic [15:0]    receiveData,
    input  logic           finalCycle,
    input  logic           transmitValid,
    output logic           transmitReady,   // one-cycle pulse at end of frame
    output logic           receiveValid,    // one-cycle pulse, read frames only
    output logic           busy,
    output logic           mdc,
    inout  wire            mdio
);

    typedef enum logic [1:0] {
        stIdle,
        stPreamble,
        stFrame,
        stFinish
    } smiState;

    smiState     state;
    logic [4:0]  bitCount;      // bit being driven, 31 down to 0
    logic [31:0] shiftReg;      // raw frame, MSB is on the wire
    logic [15:0] captureReg;
    logic        frameIsRead;
    logic        mdioOut;
    logic        mdioOe;
    logic        startFrame;
    logic        lowerTick;
    logic        raiseTick;

    assign startFrame = (state == stIdle) && finalCycle && transmitValid;
    assign lowerTick  = finalCycle && mdc;    // bits change here
    assign raiseTick  = finalCycle && !mdc;   // PHY samples here, we capture here

    // ----------------------------------------
    // control FSM

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= stIdle;
            bitCount    <= '0;
            mdc         <= 1'b0;
            mdioOut     <= 1'b1;
            mdioOe      <= 1'b0;
            frameIsRead <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (startFrame) begin
                        state       <= stPreamble;
                        bitCount    <= 5'(`SMI_PREAMBLE_BITS - 1);
                        mdioOut     <= 1'b1;   // preamble is all ones
                        mdioOe      <= 1'b1;
                        frameIsRead <= (transmitData.field.opCode == smiPkg::opRead);
                    end
                end
                stPreamble: begin
                    if (finalCycle) begin
                        mdc <= !mdc;
                        if (mdc) begin
                            if (bitCount == '0) begin
                                state    <= stFrame;
                                bitCount <= 5'd31;
                                mdioOut  <= shiftReg[31];   // start code MSB
                            end else begin
                                bitCount <= bitCount - 1'b1;
                            end
                        end
                    end
                end
                stFrame: begin
                    if (finalCycle) begin
                        mdc <= !mdc;
                        if (mdc) begin
                            if (bitCount == '0) begin
                                state  <= stFinish;
                                mdioOe <= 1'b0;             // release after last bit
                            end else begin
                                bitCount <= bitCount - 1'b1;
                                mdioOut  <= shiftReg[30];   // next bit after shift
                                // bit 17 is the first turnaround bit
                                if (frameIsRead && bitCount == 5'd18)
                                    mdioOe <= 1'b0;
                            end
                        end
                    end
                end
                stFinish: begin
                    state <= stIdle;    // one cycle to report completion
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // shift and capture

    always_ff @(posedge clk) begin
        if (startFrame)
            shiftReg <= transmitData.raw;
        else if (state == stFrame && lowerTick && bitCount != '0)
            shiftReg <= {shiftReg[30:0], 1'b0};

        // data field only, PHY owns the line here
        if (state == stFrame && raiseTick && frameIsRead && bitCount < 5'd16)
            captureReg <= {captureReg[14:0], mdio};
    end

    assign mdio = mdioOe ? mdioOut : 1'bz;

    assign receiveData   = captureReg;
    assign transmitReady = (state == stFinish);
    assign receiveValid  = (state == stFinish) && frameIsRead;
    assign busy          = (state != stIdle);

    // no contention with the PHY while it returns read data
    readRelease: assert property (@(posedge clk) disable iff (reset)
        (state == stFrame && frameIsRead && bitCount < 5'd16) |-> !mdioOe);

endmodule

// ==== hw/ethernetSmiCore.sv ====
// host-visible TX/RX registers around the serializer
// a load is only legal while transmitReady is high
`timescale 1ns/1ns

module ethernetSmiCore (
    input  logic            clk,
    input  logic            reset,
    input  smiPkg::smiFrame transmitDataIn,      // frame word from the bridge
    input  logic            transmitDataLoadEn,  // one-cycle load strobe
    input  logic            receiveDataReadReq,  // one-cycle clear of receiveValid
    output logic [15:0]     receiveData,
    output logic            receiveValid,
    output logic            transmitReady,
    output logic            mdc,
    inout  wire             mdio
);

    logic            finalCycle;
    logic            transmitReadyWire;   // end-of-frame pulse from the serializer
    logic            receiveValidWire;    // new read result pulse
    logic [15:0]     receiveDataWire;
    logic            serializerBusy;
    smiPkg::smiFrame transmitData;

    // ----------------------------------------
    // visible registers

    // frame word, stable for the whole frame since no load while not ready
    always_ff @(posedge clk) begin
        if (transmitDataLoadEn)
            transmitData <= transmitDataIn;
    end

    // read result, zero until the first read frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            receiveData <= '0;
        else if (receiveValidWire)
            receiveData <= receiveDataWire;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            receiveValid <= 1'b0;
        else if (receiveValidWire)
            receiveValid <= 1'b1;    // new result beats a clear
        else if (receiveDataReadReq)
            receiveValid <= 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            transmitReady <= 1'b1;
        else if (transmitDataLoadEn)
            transmitReady <= 1'b0;   // load beats frame done
        else if (transmitReadyWire)
            transmitReady <= 1'b1;
    end

    // ----------------------------------------
    // serializer and tick

    ethernetSmiUnit ethernetSmiUnit_i (
        .clk,
        .reset,
        .transmitData,
        .receiveData   (receiveDataWire),
        .finalCycle,
        .transmitValid (!transmitReady),
        .transmitReady (transmitReadyWire),
        .receiveValid  (receiveValidWire),
        .busy          (serializerBusy),
        .mdc,
        .mdio
    );

    ethernetSmiClockUnit ethernetSmiClockUnit_i (
        .clk,
        .reset,
        .finalCycle
    );

    // the bridge must hold off loads until both the flag and the serializer are free
    loadWhenFree: assert property (@(posedge clk) disable iff (reset)
        transmitDataLoadEn |-> transmitReady && !serializerBusy);

endmodule

// ==== hw/ethernetSmiAxiLite.sv ====
// AXI4-Lite slave, one write and one read outstanding; wstrb is not used
// only TX is writable, only RX and STATUS are readable
`timescale 1ns/1ns

module ethernetSmiAxiLite (
    input  logic            clk,
    input  logic            reset,
    input  smiPkg::axiReq   axi,
    output smiPkg::axiRsp   axiResponse,
    output smiPkg::smiFrame transmitDataIn,
    output logic            transmitDataLoadEn,
    output logic            receiveDataReadReq,
    input  logic [15:0]     receiveData,
    input  logic            receiveValid,
    input  logic            transmitReady
);

    logic            awReady, wReady, arReady;
    logic            awDone, wDone, arDone;   // address or data captured
    logic            bValid, rValid;
    logic [3:0]      awAddr, arAddr;
    smiPkg::smiFrame wData;
    logic [1:0]      bResp, rResp;
    logic [31:0]     rData;
    logic            awFire, wFire, arFire, writeFire;
    logic            awDoneNext, wDoneNext, bValidNext, arDoneNext, rValidNext;
    logic            writeOk;
    logic            readOk;
    logic [31:0]     readWord;

    // ----------------------------------------
    // handshakes

    assign awFire    = axi.awvalid && awReady;
    assign wFire     = axi.wvalid && wReady;
    assign arFire    = axi.arvalid && arReady;
    assign writeFire = awDone && wDone;     // both halves in, answer on next edge

    assign awDoneNext = (awDone || awFire) && !writeFire;
    assign wDoneNext  = (wDone || wFire) && !writeFire;
    assign bValidNext = writeFire || (bValid && !axi.bready);
    assign arDoneNext = arFire;             // decode takes one cycle
    assign rValidNext = arDone || (rValid && !axi.rready);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            arReady <= 1'b0;
            awDone  <= 1'b0;
            wDone   <= 1'b0;
            arDone  <= 1'b0;
            bValid  <= 1'b0;
            rValid  <= 1'b0;
        end else begin
            awDone  <= awDoneNext;
            wDone   <= wDoneNext;
            bValid  <= bValidNext;
            arDone  <= arDoneNext;
            rValid  <= rValidNext;
            // no new address while a response is pending
            awReady <= !awDoneNext && !bValidNext;
            wReady  <= !wDoneNext && !bValidNext;
            arReady <= !arDoneNext && !arDone && !rValidNext;
        end
    end

    // ----------------------------------------
    // decode

    assign writeOk = (awAddr == smiPkg::regTx) && transmitReady;   // busy TX is SLVERR

    always_comb begin
        readWord = '0;
        readOk   = 1'b1;
        case (arAddr)
            smiPkg::regRx:
                readWord = smiPkg::smiRxWord'{reserved: '0, valid: receiveValid,
                                              data: receiveData};
            smiPkg::regStatus:
                readWord = {30'd0, receiveValid, transmitReady};
            default:
                readOk = 1'b0;                  // unmapped, rdata stays 0
        endcase
    end

    always_ff @(posedge clk) begin
        if (awFire) awAddr <= axi.awaddr;
        if (wFire)  wData.raw <= axi.wdata;
        if (arFire) arAddr <= axi.araddr;
        if (writeFire)
            bResp <= writeOk ? smiPkg::respOkay : smiPkg::respSlvErr;
        if (arDone) begin
            rData <= readWord;
            rResp <= readOk ? smiPkg::respOkay : smiPkg::respSlvErr;
        end
    end

    // strobes line up with the captured snapshot
    assign transmitDataIn     = wData;
    assign transmitDataLoadEn = writeFire && writeOk;
    assign receiveDataReadReq = arDone && (arAddr == smiPkg::regRx);

    assign axiResponse = smiPkg::axiRsp'{awready: awReady, wready: wReady,
                                         bvalid: bValid, bresp: bResp,
                                         arready: arReady, rvalid: rValid,
                                         rdata: rData, rresp: rResp};

    // responses stay put under back-pressure
    bHold: assert property (@(posedge clk) disable iff (reset)
        bValid && !axi.bready |=> bValid && $stable(bResp));
    rHold: assert property (@(posedge clk) disable iff (reset)
        rValid && !axi.rready |=> rValid && $stable(rData) && $stable(rResp));

endmodule

// ==== hw/ethernetSmiTop.sv ====
// SMI controller top, AXI4-Lite host port in, MDC/MDIO out
// MDIO needs an external pull-up
`timescale 1ns/1ns

module ethernetSmiTop (
    input  logic          clk,
    input  logic          reset,
    input  smiPkg::axiReq axi,
    output smiPkg::axiRsp axiResponse,
    output logic          mdc,
    inout  wire           mdio
);

    // ----------------------------------------
    // bridge to core

    smiPkg::smiFrame transmitDataIn;
    logic            transmitDataLoadEn;
    logic            receiveDataReadReq;
    logic [15:0]     receiveData;
    logic            receiveValid;
    logic            transmitReady;

    ethernetSmiAxiLite ethernetSmiAxiLite_i (
        .clk,
        .reset,
        .axi,
        .axiResponse,
        .transmitDataIn,
        .transmitDataLoadEn,
        .receiveDataReadReq,
        .receiveData,
        .receiveValid,
        .transmitReady
    );

    ethernetSmiCore ethernetSmiCore_i (
        .clk,
        .reset,
        .transmitDataIn,
        .transmitDataLoadEn,
        .receiveDataReadReq,
        .receiveData,
        .receiveValid,
        .transmitReady,
        .mdc,
        .mdio
    );

endmodule

// ==== verif/smiPhyModel.sv ====
// behavioral clause 22 PHY, 32 PHY addresses x 32 registers, answers every address
// registers start at phyAddr * 256 + regAddr; MDIO needs a pull-up outside
`timescale 1ns/1ns

module smiPhyModel (
    input  logic mdc,
    inout  wire  mdio
);

    logic [15:0] regFile [0:1023];   // index is {phyAddr, regAddr}
    logic        driveEn;
    logic        driveBit;
    logic        inFrame;
    int          onesCount;          // preamble ones seen so far
    int          bitIdx;             // frame bit taken on the next rising MDC
    logic [31:0] frameBits;
    logic [15:0] readValue;

    initial begin
        for (int i = 0; i < 1024; i++)
            regFile[i] = 16'((i >> 5) * 256 + (i & 31));
        driveEn   = 1'b0;
        driveBit  = 1'b1;
        inFrame   = 1'b0;
        onesCount = 0;
        bitIdx    = 31;
        frameBits = '0;
        readValue = '0;
    end

    assign mdio = driveEn ? driveBit : 1'bz;

    // ----------------------------------------
    // frame decode, one bit per rising MDC

    always @(posedge mdc) begin
        logic sample;
        logic isRead;
        sample = (mdio === 1'b0) ? 1'b0 : 1'b1;   // released line reads as one
        if (!inFrame) begin
            if (sample) begin
                onesCount = onesCount + 1;
            end else begin
                // first zero after a full preamble is the start code MSB
                if (onesCount >= 32) begin
                    inFrame   = 1'b1;
                    frameBits = '0;
                    bitIdx    = 30;
                end
                onesCount = 0;
            end
        end else begin
            frameBits[bitIdx] = sample;
            isRead = (frameBits[31:30] == 2'b01) && (frameBits[29:28] == 2'b10);
            if (isRead && bitIdx == 17) begin
                readValue = regFile[frameBits[27:18]];
                driveBit <= 1'b0;                   // second turnaround bit
                driveEn  <= 1'b1;
            end else if (isRead && bitIdx <= 16 && bitIdx >= 1) begin
                driveBit <= readValue[bitIdx-1];    // ready before the next rise
            end
            if (bitIdx == 0) begin
                if (frameBits[31:30] == 2'b01 && frameBits[29:28] == 2'b01)
                    regFile[frameBits[27:18]] = frameBits[15:0];
                driveEn   <= 1'b0;
                inFrame   = 1'b0;
                onesCount = 0;
            end else begin
                bitIdx = bitIdx - 1;
            end
        end
    end

endmodule

// ==== verif/ethernetSmiTb.sv ====
// testbench for the SMI controller with a behavioral PHY and a pull-up on MDIO
// frameCount must cover every frame the tests send since it sizes the watchdog
`timescale 1ns/1ns
`include "smi_defs.svh"

module ethernetSmiTb;

    localparam int     frameCount = 25;
    localparam longint watchdogNs =
        longint'(frameCount) * 64 * 2 * `SMI_CLOCK_DIVIDE * 40 * 2;

    logic          clk;
    logic          reset;
    smiPkg::axiReq axi;
    smiPkg::axiRsp axiResponse;
    logic          mdc;
    wire           mdio;

    logic [15:0] shadow  [0:1023];   // PHY registers as the host wrote them
    bit          written [0:1023];

    smiPkg::smiRxWord gotQ[$];       // RX words seen on the bus
    smiPkg::smiRxWord expQ[$];       // what the reference says they should be

    int errorCount;
    int testCount;
    int failedTests;
    int errorsAtStart;
    int mdcRises;                    // rising MDC edges since the start

    pullup (mdio);

    ethernetSmiTop ethernetSmiTop_i (
        .clk,
        .reset,
        .axi,
        .axiResponse,
        .mdc,
        .mdio
    );

    smiPhyModel phyModel (
        .mdc,
        .mdio
    );

    always #20 clk = ~clk;

    always @(posedge mdc) mdcRises++;

    // ----------------------------------------
    // reference and compares

    function automatic logic [15:0] expectedRead(input logic [4:0] phyAddr,
                                                 input logic [4:0] regAddr);
        if (written[{phyAddr, regAddr}])
            return shadow[{phyAddr, regAddr}];
        return 16'(int'(phyAddr) * 256 + int'(regAddr));   // never written
    endfunction

    function automatic smiPkg::smiRxWord rxWord(input logic valid, input logic [15:0] data);
        smiPkg::smiRxWord w;
        w          = '0;
        w.valid    = valid;
        w.data     = data;
        return w;
    endfunction

    function automatic smiPkg::smiFrame makeFrame(input smiPkg::smiOp op,
                                                  input logic [4:0] phyAddr,
                                                  input logic [4:0] regAddr,
                                                  input logic [15:0] data);
        smiPkg::smiFrame f;
        f.field.startCode  = 2'b01;
        f.field.opCode     = op;
        f.field.phyAddr    = phyAddr;
        f.field.regAddr    = regAddr;
        f.field.turnaround = 2'b10;
        f.field.data       = data;
        return f;
    endfunction

    task automatic checkRx(input smiPkg::smiRxWord got, input smiPkg::smiRxWord exp);
        if (got !== exp) begin
            $display("error RX rdata: got 0x%08h, expected 0x%08h", got, exp);
            errorCount++;
        end
    endtask

    task automatic checkResp(input logic [1:0] got, input smiPkg::smiResp exp,
                             input string what);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkStatus(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error %s: got 0x%08h, expected 0x%08h", what, got, exp);
            errorCount++;
        end
    endtask

    // one frame is preamble plus 32 frame bits, MDC idles low afterwards
    task automatic checkMdc(input int rises, input logic level);
        if (rises != `SMI_PREAMBLE_BITS + 32) begin
            $display("error mdc periods: got 0x%0h, expected 0x%0h", rises,
                     `SMI_PREAMBLE_BITS + 32);
            errorCount++;
        end
        if (level !== 1'b0) begin
            $display("error mdc: got 0x%0h, expected 0x0", level);
            errorCount++;
        end
    endtask

    // pairs RX words with their expectations as they arrive
    always @(negedge clk) begin
        while (gotQ.size() != 0 && expQ.size() != 0)
            checkRx(gotQ.pop_front(), expQ.pop_front());
    end

    // ----------------------------------------
    // AXI4-Lite host driving on the falling edge

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            input int awLag, input int wLag, input int bLag,
                            output logic [1:0] resp);
        bit awDone;
        bit wDone;
        bit awGo;
        bit wGo;
        int cyc;
        awDone = 1'b0;
        wDone  = 1'b0;
        cyc    = 0;
        @(negedge clk);
        while (!(awDone && wDone)) begin
            if (!awDone && cyc == awLag) begin
                axi.awvalid = 1'b1;
                axi.awaddr  = addr;
            end
            if (!wDone && cyc == wLag) begin
                axi.wvalid = 1'b1;
                axi.wdata  = data;
                axi.wstrb  = 4'hf;
            end
            awGo = axi.awvalid && axiResponse.awready;   // transfers on the next rise
            wGo  = axi.wvalid && axiResponse.wready;
            @(negedge clk);
            cyc++;
            if (awGo) begin
                axi.awvalid = 1'b0;
                awDone      = 1'b1;
            end
            if (wGo) begin
                axi.wvalid = 1'b0;
                wDone      = 1'b1;
            end
        end
        while (!axiResponse.bvalid)
            @(negedge clk);
        repeat (bLag) @(negedge clk);       // late bready
        if (!axiResponse.bvalid) begin
            $display("write response to 0x%0h was withdrawn before bready", addr);
            errorCount++;
        end
        resp       = axiResponse.bresp;
        axi.bready = 1'b1;
        @(negedge clk);
        axi.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, input int rLag,
                           output logic [31:0] data, output logic [1:0] resp);
        @(negedge clk);
        axi.arvalid = 1'b1;
        axi.araddr  = addr;
        while (!axiResponse.arready)
            @(negedge clk);
        @(negedge clk);
        axi.arvalid = 1'b0;
        while (!axiResponse.rvalid)
            @(negedge clk);
        repeat (rLag) @(negedge clk);       // late rready
        if (!axiResponse.rvalid) begin
            $display("read response from 0x%0h was withdrawn before rready", addr);
            errorCount++;
        end
        data       = axiResponse.rdata;
        resp       = axiResponse.rresp;
        axi.rready = 1'b1;
        @(negedge clk);
        axi.rready = 1'b0;
    endtask

    // ----------------------------------------
    // frame level helpers

    task automatic sendFrame(input smiPkg::smiFrame f, input smiPkg::smiResp exp);
        logic [1:0] resp;
        axiWrite(`SMI_REG_TX, f.raw, 0, 0, 0, resp);
        checkResp(resp, exp, "bresp");
    endtask

    task automatic waitReady();
        logic [31:0] status;
        logic [1:0]  resp;
        status = '0;
        while (!status[0]) begin           // poll until the frame has gone out
            axiRead(`SMI_REG_STATUS, 0, status, resp);
            checkResp(resp, smiPkg::respOkay, "rresp");
        end
    endtask

    task automatic readRxExpect(input smiPkg::smiRxWord exp);
        logic [31:0] data;
        logic [1:0]  resp;
        expQ.push_back(exp);
        axiRead(`SMI_REG_RX, 0, data, resp);
        checkResp(resp, smiPkg::respOkay, "rresp");
        gotQ.push_back(smiPkg::smiRxWord'(data));
    endtask

    task automatic writeFrame(input logic [4:0] phyAddr, input logic [4:0] regAddr,
                              input logic [15:0] data);
        int risesBefore;
        risesBefore = mdcRises;
        sendFrame(makeFrame(smiPkg::opWrite, phyAddr, regAddr, data), smiPkg::respOkay);
        shadow[{phyAddr, regAddr}]  = data;
        written[{phyAddr, regAddr}] = 1'b1;
        waitReady();
        checkMdc(mdcRises - risesBefore, mdc);
    endtask

    task automatic readFrame(input logic [4:0] phyAddr, input logic [4:0] regAddr);
        int risesBefore;
        risesBefore = mdcRises;
        sendFrame(makeFrame(smiPkg::opRead, phyAddr, regAddr, 16'h0), smiPkg::respOkay);
        waitReady();
        checkMdc(mdcRises - risesBefore, mdc);
        readRxExpect(rxWord(1'b1, expectedRead(phyAddr, regAddr)));
    endtask

    task automatic endTest(input string name);
        while (gotQ.size() != 0)
            @(negedge clk);
        testCount++;
        if (errorCount != errorsAtStart) begin
            failedTests++;
            $display("%-26s FAILED, %0d errors", name, errorCount - errorsAtStart);
        end else begin
            $display("%-26s ok", name);
        end
        errorsAtStart = errorCount;
    endtask

    // ----------------------------------------
    // watchdog

    initial begin
        #(watchdogNs);
        $display("watchdog: run did not finish within %0d ns, a frame or handshake hung",
                 watchdogNs);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------
    // test sequence

    initial begin
        logic [4:0]  phyAddr;
        logic [4:0]  regAddr;
        logic [15:0] data;
        logic [31:0] rdata;
        logic [1:0]  resp;
        clk           = 1'b0;
        reset         = 1'b1;
        axi           = '0;
        errorCount    = 0;
        testCount     = 0;
        failedTests   = 0;
        errorsAtStart = 0;
        mdcRises      = 0;
        for (int i = 0; i < 1024; i++)
            written[i] = 1'b0;
        void'($urandom(32'h2e63a4dc));
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // 1 idle state after reset
        axiRead(`SMI_REG_STATUS, 0, rdata, resp);
        checkResp(resp, smiPkg::respOkay, "rresp");
        checkStatus(rdata, 32'h1, "STATUS rdata");
        readRxExpect(rxWord(1'b0, 16'h0));
        endTest("reset state");

        // 2 write then read back
        phyAddr = 5'($urandom_range(0, 31));
        regAddr = 5'($urandom_range(0, 31));
        data    = 16'($urandom);
        writeFrame(phyAddr, regAddr, data);
        readFrame(phyAddr, regAddr);
        endTest("write and read back");

        // 3 untouched register and the RX clear on read
        do begin
            phyAddr = 5'($urandom_range(0, 31));
            regAddr = 5'($urandom_range(0, 31));
        end while (written[{phyAddr, regAddr}]);
        readFrame(phyAddr, regAddr);
        readRxExpect(rxWord(1'b0, expectedRead(phyAddr, regAddr)));
        endTest("initial value and clear");

        // 4 TX write while busy is refused and the running frame survives
        phyAddr = 5'($urandom_range(0, 31));
        regAddr = 5'($urandom_range(0, 31));
        data    = 16'($urandom);
        sendFrame(makeFrame(smiPkg::opWrite, phyAddr, regAddr, data), smiPkg::respOkay);
        shadow[{phyAddr, regAddr}]  = data;
        written[{phyAddr, regAddr}] = 1'b1;
        sendFrame(makeFrame(smiPkg::opWrite, phyAddr, regAddr, ~data), smiPkg::respSlvErr);
        axiRead(`SMI_REG_STATUS, 0, rdata, resp);
        checkResp(resp, smiPkg::respOkay, "rresp");
        checkStatus(rdata, 32'h0, "STATUS rdata");
        waitReady();
        readFrame(phyAddr, regAddr);
        endTest("busy write refused");

        // 5 unmapped offsets and back-pressure
        for (int i = 0; i < 6; i++) begin
            axiRead(4'hc, $urandom_range(0, 4), rdata, resp);
            checkResp(resp, smiPkg::respSlvErr, "rresp");
            checkStatus(rdata, 32'h0, "rdata");
            axiRead(`SMI_REG_TX, $urandom_range(0, 4), rdata, resp);
            checkResp(resp, smiPkg::respSlvErr, "rresp");
            checkStatus(rdata, 32'h0, "rdata");
            axiRead(`SMI_REG_STATUS, $urandom_range(0, 4), rdata, resp);
            checkResp(resp, smiPkg::respOkay, "rresp");
            checkStatus(rdata, 32'h1, "STATUS rdata");
            // address and data in either order
            axiWrite(4'hc, $urandom, $urandom_range(0, 2), $urandom_range(0, 2),
                     $urandom_range(0, 4), resp);
            checkResp(resp, smiPkg::respSlvErr, "bresp");
            axiWrite(`SMI_REG_RX, $urandom, 0, $urandom_range(0, 2),
                     $urandom_range(0, 4), resp);
            checkResp(resp, smiPkg::respSlvErr, "bresp");
        end
        endTest("unmapped and back-pressure");

        // 6 random traffic over a small address set so reads hit writes
        for (int i = 0; i < 20; i++) begin
            phyAddr = 5'($urandom_range(0, 3));
            regAddr = 5'($urandom_range(0, 7));
            if ($urandom_range(0, 1) == 1)
                writeFrame(phyAddr, regAddr, 16'($urandom));
            else
                readFrame(phyAddr, regAddr);
        end
        endTest("random frames");

        $display("tests %0d, failing %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/smiPkg.sv
hw/ethernetSmiClockUnit.sv
hw/ethernetSmiUnit.sv
hw/ethernetSmiCore.sv
hw/ethernetSmiAxiLite.sv
hw/ethernetSmiTop.sv
verif/smiPhyModel.sv
verif/ethernetSmiTb.sv

// ==== Makefile ====
# Verilator flow for the SMI controller

TOP = ethernetSmiTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module ethernetSmiTop
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
